// File: src/ahb_bus_pkg.sv
// AHB bus package with transfer types, response codes and request/response structs
package ahb_bus_pkg;

  typedef logic [31:0] haddr_t;
  typedef logic [31:0] hdata_t;
  typedef logic [2:0]  hsize_t;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01
  } hresp_e;

  // 38-bit address phase
  typedef struct packed {
    haddr_t  haddr;
    htrans_e htrans;
    logic    hwrite;
    hsize_t  hsize;
  } ahb_req_t;

  // 35-bit data phase return
  typedef struct packed {
    hdata_t  hrdata;
    hresp_e  hresp;
    logic    hready;
  } ahb_rsp_t;

endpackage

// File: src/ahb_map_pkg.sv
// AHB map package with bus sizes, master and slave select types and the default address map
package ahb_map_pkg;

  localparam int NUM_M = 3;
  localparam int NUM_S = 4;

  typedef logic [$clog2(NUM_M)-1:0] master_t;
  typedef logic [NUM_S:0]           slave_sel_t;  // msb is the default slave

  //------------------------------------------------------------
  // default windows of 64 KB each
  //------------------------------------------------------------
  localparam logic [NUM_S-1:0][31:0] DEF_BASE = {
    32'h3000_0000, 32'h2000_0000, 32'h1000_0000, 32'h0000_0000
  };
  localparam logic [NUM_S-1:0][31:0] DEF_SIZE = {
    32'h0001_0000, 32'h0001_0000, 32'h0001_0000, 32'h0001_0000
  };

endpackage

// File: src/ahb_arbiter.sv
// AHB arbiter with fixed priority grant, rotation mask and registered master number
`timescale 1ns/1ps

module ahb_arbiter (
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  logic [ahb_map_pkg::NUM_M-1:0] hbusreq,   // bit 0 highest priority
  input  logic                          hready,
  output logic [ahb_map_pkg::NUM_M-1:0] hgrant,
  output ahb_map_pkg::master_t          hmaster
);
  import ahb_map_pkg::*;

  typedef enum logic {ST_IDLE, ST_OWNED} arb_state_e;

  arb_state_e       state;
  logic [NUM_M-1:0] mask;      // 1 = skipped on rotation
  logic [NUM_M-1:0] unmasked;
  master_t          owner;

  // lowest set bit only
  function automatic logic [NUM_M-1:0] first_req(input logic [NUM_M-1:0] req);
    return req & (~req + 1'b1);
  endfunction

  function automatic master_t encode(input logic [NUM_M-1:0] onehot);
    master_t idx;
    idx = '0;
    for (int i = NUM_M - 1; i >= 0; i--) begin
      if (onehot[i]) begin
        idx = master_t'(i);
      end
    end
    return idx;
  endfunction

  assign owner    = encode(hgrant);
  assign unmasked = hbusreq & ~mask;

  //------------------------------------------------------------
  // grant FSM frozen while the data phase waits
  //------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state   <= ST_IDLE;
      hgrant  <= '0;
      hmaster <= '0;
      mask    <= '0;
    end else if (hready) begin
      hmaster <= owner;   // one cycle behind hgrant
      case (state)
        ST_IDLE: begin
          if (|hbusreq) begin
            hgrant <= first_req(hbusreq);
            mask   <= '0;
            state  <= ST_OWNED;
          end
        end
        ST_OWNED: begin
          if (!(|hbusreq)) begin
            hgrant <= '0;
            mask   <= '0;
            state  <= ST_IDLE;
          end else if (!hbusreq[owner]) begin
            if (|unmasked) begin
              hgrant      <= first_req(unmasked);
              mask[owner] <= 1'b1;   // rotate away from the old owner
            end else begin
              hgrant <= first_req(hbusreq);   // all masked so plain priority
              mask   <= '0;
            end
          end
        end
      endcase
    end
  end

  // any request in a ready cycle leaves exactly one master granted
  a_grant_onehot: assert property (
    @(posedge HCLK) disable iff (!HRESETn) hready && |hbusreq |=> $onehot(hgrant)
  );

endmodule

// File: src/ahb_master_mux.sv
// AHB master mux passing the owner's address phase and the previous owner's write data
`timescale 1ns/1ps

module ahb_master_mux (
  input  logic                                           HCLK,
  input  logic                                           HRESETn,
  input  logic                                           hready,
  input  ahb_map_pkg::master_t                           hmaster,
  input  ahb_bus_pkg::ahb_req_t [ahb_map_pkg::NUM_M-1:0] m_req,
  input  ahb_bus_pkg::hdata_t   [ahb_map_pkg::NUM_M-1:0] m_hwdata,
  output ahb_bus_pkg::ahb_req_t                          s_req,
  output ahb_bus_pkg::hdata_t                            s_hwdata
);
  import ahb_map_pkg::*;

  master_t hmaster_d;   // owner of the data phase

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      hmaster_d <= '0;
    end else if (hready) begin
      hmaster_d <= hmaster;
    end
  end

  // out of range number drives an IDLE transfer
  always_comb begin
    s_req = '0;
    if (hmaster < NUM_M) begin
      s_req = m_req[hmaster];
    end
  end

  always_comb begin
    s_hwdata = '0;
    if (hmaster_d < NUM_M) begin
      s_hwdata = m_hwdata[hmaster_d];
    end
  end

endmodule

// File: src/ahb_decoder.sv
// AHB address decoder with window compare per slave, remap swap and default-slave select
`timescale 1ns/1ps

module ahb_decoder #(
  parameter logic [ahb_map_pkg::NUM_S-1:0][31:0] BASE = ahb_map_pkg::DEF_BASE,
  parameter logic [ahb_map_pkg::NUM_S-1:0][31:0] SIZE = ahb_map_pkg::DEF_SIZE
) (
  input  ahb_bus_pkg::haddr_t            haddr,
  input  logic                           remap,
  output logic [ahb_map_pkg::NUM_S-1:0]  s_hsel,
  output logic                           def_sel
);
  import ahb_map_pkg::*;

  logic [NUM_S-1:0] hit;

  always_comb begin
    // base <= haddr < base + size in one unsigned compare
    for (int i = 0; i < NUM_S; i++) begin
      hit[i] = (haddr - BASE[i]) < SIZE[i];
    end
    s_hsel = hit;
    if (remap) begin
      s_hsel[0] = hit[1];   // boot swap
      s_hsel[1] = hit[0];
    end
    def_sel = ~|hit;
  end

  // windows must not overlap
  always_comb begin
    if (!$isunknown(haddr)) begin
      a_sel_onehot: assert ($onehot({def_sel, s_hsel}));
    end
  end

endmodule

// File: src/ahb_default_slave.sv
// AHB default slave giving a two-cycle ERROR response to transfers to unmapped addresses
`timescale 1ns/1ps

module ahb_default_slave (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  sel,
  input  ahb_bus_pkg::htrans_e  htrans,
  input  logic                  hready,
  output ahb_bus_pkg::ahb_rsp_t rsp
);
  import ahb_bus_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_ERR1, ST_ERR2} def_state_e;

  def_state_e state;
  logic       start;

  assign start = sel && hready && (htrans == NONSEQ || htrans == SEQ);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE, ST_ERR2: state <= start ? ST_ERR1 : ST_IDLE;   // back to back allowed
        ST_ERR1:          state <= ST_ERR2;
        default:          state <= ST_IDLE;
      endcase
    end
  end

  //------------------------------------------------------------
  // response per state
  //------------------------------------------------------------
  always_comb begin
    rsp.hrdata = '0;
    case (state)
      ST_ERR1: begin
        rsp.hresp  = ERROR;
        rsp.hready = 1'b0;   // wait cycle
      end
      ST_ERR2: begin
        rsp.hresp  = ERROR;
        rsp.hready = 1'b1;
      end
      default: begin
        rsp.hresp  = OKAY;
        rsp.hready = 1'b1;
      end
    endcase
  end

  // our wait state stalls the bus
  a_wait_on_bus: assert property (
    @(posedge HCLK) disable iff (!HRESETn) !rsp.hready |-> !hready
  );

  // and the bus runs again one cycle later
  a_one_wait: assert property (
    @(posedge HCLK) disable iff (!HRESETn) !rsp.hready |=> hready
  );

endmodule

// File: src/ahb_response_mux.sv
// AHB response mux that holds the data-phase slave select and returns that slave's response
`timescale 1ns/1ps

module ahb_response_mux (
  input  logic                                           HCLK,
  input  logic                                           HRESETn,
  input  logic                  [ahb_map_pkg::NUM_S-1:0] s_hsel,
  input  logic                                           def_sel,
  input  ahb_bus_pkg::ahb_rsp_t [ahb_map_pkg::NUM_S-1:0] s_rsp,
  input  ahb_bus_pkg::ahb_rsp_t                          def_rsp,
  output ahb_bus_pkg::ahb_rsp_t                          m_rsp
);
  import ahb_bus_pkg::*;
  import ahb_map_pkg::*;

  localparam ahb_rsp_t NO_RSP = '{hrdata: '0, hresp: OKAY, hready: 1'b1};

  slave_sel_t sel_q;   // select of the current data phase

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      sel_q <= '0;
    end else if (m_rsp.hready) begin
      sel_q <= {def_sel, s_hsel};
    end
  end

  always_comb begin
    m_rsp = NO_RSP;   // empty or broken select
    for (int i = 0; i < NUM_S; i++) begin
      if (sel_q == slave_sel_t'(1 << i)) begin
        m_rsp = s_rsp[i];
      end
    end
    if (sel_q == slave_sel_t'(1 << NUM_S)) begin
      m_rsp = def_rsp;
    end
  end

endmodule

// File: src/ahb_bus_m3s4.sv
// AHB bus top with three masters, four slaves and a default slave on one shared bus
`timescale 1ns/1ps

module ahb_bus_m3s4 #(
  parameter logic [ahb_map_pkg::NUM_S-1:0][31:0] BASE = ahb_map_pkg::DEF_BASE,
  parameter logic [ahb_map_pkg::NUM_S-1:0][31:0] SIZE = ahb_map_pkg::DEF_SIZE
) (
  input  logic                                           HCLK,
  input  logic                                           HRESETn,
  // master side
  input  logic                  [ahb_map_pkg::NUM_M-1:0] hbusreq,
  input  ahb_bus_pkg::ahb_req_t [ahb_map_pkg::NUM_M-1:0] m_req,
  input  ahb_bus_pkg::hdata_t   [ahb_map_pkg::NUM_M-1:0] m_hwdata,
  output logic                  [ahb_map_pkg::NUM_M-1:0] hgrant,
  output ahb_bus_pkg::ahb_rsp_t                          m_rsp,
  // slave side
  output ahb_bus_pkg::ahb_req_t                          s_req,
  output ahb_bus_pkg::hdata_t                            s_hwdata,
  output logic                                           s_hready,
  output logic                  [ahb_map_pkg::NUM_S-1:0] s_hsel,
  input  ahb_bus_pkg::ahb_rsp_t [ahb_map_pkg::NUM_S-1:0] s_rsp,
  input  logic                                           remap
);
  import ahb_bus_pkg::*;
  import ahb_map_pkg::*;

  master_t  hmaster;
  logic     def_sel;
  ahb_rsp_t def_rsp;

  assign s_hready = m_rsp.hready;

  //------------------------------------------------------------
  // master side
  //------------------------------------------------------------
  ahb_arbiter u_arbiter (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .hbusreq (hbusreq),
    .hready  (m_rsp.hready),
    .hgrant  (hgrant),
    .hmaster (hmaster)
  );

  ahb_master_mux u_master_mux (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .hready   (m_rsp.hready),
    .hmaster  (hmaster),
    .m_req    (m_req),
    .m_hwdata (m_hwdata),
    .s_req    (s_req),
    .s_hwdata (s_hwdata)
  );

  //------------------------------------------------------------
  // decode and return path
  //------------------------------------------------------------
  ahb_decoder #(
    .BASE (BASE),
    .SIZE (SIZE)
  ) u_decoder (
    .haddr   (s_req.haddr),
    .remap   (remap),
    .s_hsel  (s_hsel),
    .def_sel (def_sel)
  );

  ahb_default_slave u_default_slave (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .sel     (def_sel),
    .htrans  (s_req.htrans),
    .hready  (m_rsp.hready),
    .rsp     (def_rsp)
  );

  ahb_response_mux u_response_mux (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .s_hsel  (s_hsel),
    .def_sel (def_sel),
    .s_rsp   (s_rsp),
    .def_rsp (def_rsp),
    .m_rsp   (m_rsp)
  );

endmodule

// File: sim/tb_ahb_bus.sv
// AHB bus testbench that replays a stimulus file cycle by cycle and checks the bus outputs
`timescale 1ns/1ps

module tb_ahb_bus;
  import ahb_bus_pkg::*;
  import ahb_map_pkg::*;

  localparam string STIM_FILE    = "sim/ahb_bus_stim.txt";
  localparam int    RESET_CYCLES = 8;

  logic                 HCLK;
  logic                 HRESETn;
  logic [NUM_M-1:0]     hbusreq;
  ahb_req_t [NUM_M-1:0] m_req;
  hdata_t [NUM_M-1:0]   m_hwdata;
  logic [NUM_M-1:0]     hgrant;
  ahb_rsp_t             m_rsp;
  ahb_req_t             s_req;
  hdata_t               s_hwdata;
  logic                 s_hready;
  logic [NUM_S-1:0]     s_hsel;
  ahb_rsp_t [NUM_S-1:0] s_rsp;
  logic                 remap;

  int mismatches   = 0;
  int other_errors = 0;
  int cycles       = 0;
  int cycle_limit  = RESET_CYCLES + 20;   // grows by one per stimulus line

  ahb_bus_m3s4 u_dut (.*);

  always #10 HCLK = ~HCLK;

  //------------------------------------------------------------
  // per-cycle data patterns
  //------------------------------------------------------------
  function automatic hdata_t wdata_of(input int idx, input int line_no);
    return 32'hd000_0000 | (idx << 16) | line_no;
  endfunction

  function automatic hdata_t rdata_of(input int idx, input int line_no);
    return 32'h5a00_0000 | (idx << 16) | line_no;
  endfunction

  function automatic ahb_req_t req_of(input int idx, input haddr_t addr, input htrans_e tr);
    ahb_req_t r;
    r.haddr  = addr;
    r.htrans = tr;
    r.hwrite = idx[0];   // odd masters write
    r.hsize  = 3'd2;
    return r;
  endfunction

  //------------------------------------------------------------
  // compare tasks
  //------------------------------------------------------------
  task automatic check_grant(input string name, input logic [NUM_M-1:0] exp,
                             input logic [NUM_M-1:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s hgrant: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_master(input string name, input master_t exp, input master_t act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s hmaster: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_req(input string name, input ahb_req_t exp, input ahb_req_t act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s s_req: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input hdata_t exp, input hdata_t act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s s_hwdata: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_sel(input string name, input logic [NUM_S-1:0] exp,
                           input logic [NUM_S-1:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s s_hsel: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s s_hready: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_rsp(input string name, input ahb_rsp_t exp, input ahb_rsp_t act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s m_rsp (data/resp/ready): expected %h/%0d/%b, actual %h/%0d/%b",
               name, exp.hrdata, exp.hresp, exp.hready, act.hrdata, act.hresp, act.hready);
    end
  endtask

  initial begin
    int       fd;
    int       n;
    int       line_no;
    int       req, rmp, tr, srdy;
    int       e_grant, e_master, e_sel, e_src, e_ready, e_resp, e_wm;
    haddr_t   addr [NUM_M];
    string    line;
    string    name;
    logic [8*12-1:0] tag;
    ahb_rsp_t exp_rsp;

    HCLK     = 1'b0;
    HRESETn  = 1'b0;
    hbusreq  = '0;
    m_req    = '0;
    m_hwdata = '0;
    s_rsp    = '0;
    remap    = 1'b0;
    line_no  = 0;

    // first pass sizes the timeout
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      other_errors++;
      $display("cannot open stimulus file %s", STIM_FILE);
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          cycle_limit++;
        end
      end
      $fclose(fd);
    end

    repeat (RESET_CYCLES) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;

    fd = $fopen(STIM_FILE, "r");
    while (fd != 0 && $fgets(line, fd) > 0) begin
      if (line.len() <= 1 || line.getc(0) == "#") begin
        continue;
      end
      line_no++;
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  tag, req, rmp, tr, addr[0], addr[1], addr[2], srdy,
                  e_grant, e_master, e_sel, e_src, e_ready, e_resp, e_wm);
      if (n != 15) begin
        other_errors++;
        $display("stimulus line %0d has %0d fields instead of 15", line_no, n);
        continue;
      end
      name    = $sformatf("%0s", tag);
      hbusreq = req[NUM_M-1:0];
      remap   = rmp[0];
      for (int i = 0; i < NUM_M; i++) begin
        m_req[i]    = req_of(i, addr[i], htrans_e'(tr[1:0]));
        m_hwdata[i] = wdata_of(i, line_no);
      end
      for (int i = 0; i < NUM_S; i++) begin
        s_rsp[i] = '{hrdata: rdata_of(i, line_no), hresp: OKAY, hready: srdy[i]};
      end

      @(posedge HCLK);
      #1;
      exp_rsp.hrdata = (e_src < NUM_S) ? rdata_of(e_src, line_no) : '0;  // src 4 has no data
      exp_rsp.hresp  = hresp_e'(e_resp[1:0]);
      exp_rsp.hready = e_ready[0];
      check_grant(name, e_grant[NUM_M-1:0], hgrant);
      check_master(name, master_t'(e_master), u_dut.hmaster);
      check_req(name, m_req[e_master[1:0]], s_req);
      check_data(name, wdata_of(e_wm, line_no), s_hwdata);
      check_sel(name, e_sel[NUM_S-1:0], s_hsel);
      check_ready(name, e_ready[0], s_hready);
      check_rsp(name, exp_rsp, m_rsp);
      @(negedge HCLK);
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (line_no == 0) begin
      other_errors++;
      $display("no stimulus lines were read");
    end

    $display("lines %0d, mismatches %0d, other errors %0d", line_no, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  always @(posedge HCLK) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout, the stimulus did not finish within %0d cycles", cycle_limit);
      $display("lines unknown, mismatches %0d, other errors %0d", mismatches, other_errors);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

// File: sim/ahb_bus_stim.txt
# in:  tag hbusreq remap htrans haddr0 haddr1 haddr2 slave_ready_mask
# out: hgrant hmaster s_hsel rsp_src(4 = no slave data) hready hresp wdata_master
prio0    6 0 2 00000100 10000200 20000300 f   2 0 1 0 1 0 0
prio1    7 0 2 00000100 10000200 20000300 f   2 1 2 0 1 0 0
prio2    7 0 2 00000100 10000200 20000300 f   2 1 2 1 1 0 1
rot0     5 0 2 00000100 10000200 20000300 f   1 1 2 1 1 0 1
rot1     5 0 2 00000100 10000200 20000300 f   1 0 1 1 1 0 1
rot2     6 0 2 00000100 10000200 20000300 f   4 0 1 0 1 0 0
rot3     6 0 2 00000100 10000200 20000300 f   4 2 4 0 1 0 0
rot4     2 0 2 00000100 10000200 20000300 f   2 2 4 2 1 0 2
rot5     2 0 2 00000100 10000200 20000300 f   2 1 2 2 1 0 2
remap0   2 1 2 00000100 10000200 20000300 f   2 1 1 0 1 0 1
remap1   2 1 2 00000100 00000400 20000300 f   2 1 2 1 1 0 1
dec3     2 0 2 00000100 3000fffc 20000300 f   2 1 8 3 1 0 1
decnone  2 0 0 00000100 20010000 20000300 f   2 1 0 4 1 0 1
bp0      2 0 2 00000100 20000010 20000300 f   2 1 4 2 1 0 1
bp1      1 0 2 00000100 20000010 20000300 b   2 1 4 2 0 0 1
bp2      1 0 2 00000100 20000010 20000300 b   2 1 4 2 0 0 1
bp3      1 0 2 00000100 20000010 20000300 f   1 1 4 2 1 0 1
bp4      1 0 2 40000000 20000010 20000300 f   1 0 0 2 1 0 1
def0     1 0 2 40000000 20000010 20000300 f   1 0 0 4 0 1 0
def1     1 0 2 40000000 20000010 20000300 f   1 0 0 4 1 1 0
def2     1 0 0 40000000 20000010 20000300 f   1 0 0 4 1 0 0
idle0    0 0 0 00000100 20000010 20000300 f   0 0 1 0 1 0 0
idle1    0 0 0 00000100 20000010 20000300 f   0 0 1 0 1 0 0

// File: ahb_bus_m3s4.f
src/ahb_bus_pkg.sv
src/ahb_map_pkg.sv
src/ahb_arbiter.sv
src/ahb_master_mux.sv
src/ahb_decoder.sv
src/ahb_default_slave.sv
src/ahb_response_mux.sv
src/ahb_bus_m3s4.sv
sim/tb_ahb_bus.sv

// File: Makefile
TOP := tb_ahb_bus

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f ahb_bus_m3s4.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
